//--- Makefile
# Verilator build and run for the RV32 execute stage

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= executeStageTb
RTL_TOP   ?= executeStage
FILELIST  ?= rvExecute.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		hw/execTypes.sv hw/intAlu.sv hw/mulDivUnit.sv hw/operandBypass.sv hw/executeStage.sv

clean:
	rm -rf $(OBJDIR)

//--- hw/execTypes.sv
// ----------------------------------------
// shared widths and opcode encodings for the RV32 execute stage
// enum widths are fixed and upstream decode must match them
// ----------------------------------------
`default_nettype none

package execTypes;

    localparam int XLEN = 32;
    localparam int XLEN_LOG2 = 5;
    localparam int REG_ADDR_W = 5;
    localparam int INSN_SIZE = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluClear1,
        aluClear2
    } aluCommand_t;

    typedef enum logic [2:0] {
        branchEqual,
        branchNotEqual,
        branchLessThan,
        branchGreaterEqual,
        branchUnsignedLessThan,
        branchUnsignedGreaterEqual,
        branchAlways
    } branchType_t;

    // RISC-V M extension order
    typedef enum logic [2:0] {
        mdMul,
        mdMulh,
        mdMulhsu,
        mdMulhu,
        mdDiv,
        mdDivu,
        mdRem,
        mdRemu
    } mulDivType_t;

    typedef enum logic {
        exUnitAlu,
        exUnitMulDiv
    } exUnitType_t;

    typedef enum logic [1:0] {
        src1Zero,
        src1Pc,
        src1Reg
    } aluSrc1Type_t;

    typedef enum logic [1:0] {
        src2Zero,
        src2Imm,
        src2Reg
    } aluSrc2Type_t;

    typedef enum logic {
        dstResult,
        dstNextPc
    } dstSrcType_t;

endpackage

`default_nettype wire

//--- hw/executeStage.sv
// ----------------------------------------
// RV32 integer execute stage, one op per cycle
// upstream must hold all inputs while stall is high
// no downstream back-pressure; results appear one cycle later
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module executeStage import execTypes::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         valid,
    input  exUnitType_t  exUnitType,
    input  aluCommand_t  aluCommand,
    input  aluSrc1Type_t aluSrc1Type,
    input  aluSrc2Type_t aluSrc2Type,
    input  mulDivType_t  mulDivType,
    input  logic         isBranch,
    input  branchType_t  branchType,
    input  dstSrcType_t  dstSrcType,
    input  logic         regWriteEnable,
    input  regAddr_t     srcRegAddr1,
    input  regAddr_t     srcRegAddr2,
    input  regAddr_t     dstRegAddr,
    input  word_t        srcRegValue1,
    input  word_t        srcRegValue2,
    input  word_t        pc,
    input  word_t        imm,
    output logic         stall,
    output logic         outValid,
    output logic         outRegWrite,
    output regAddr_t     outDstRegAddr,
    output word_t        outDstValue,
    output logic         outBranchTaken,
    output word_t        outNextPc
);

    word_t srcValue1;
    word_t srcValue2;
    word_t aluSrc1;
    word_t aluSrc2;
    word_t aluResult;
    logic  condition;
    word_t mulDivResult;
    logic  mulDivDone;
    logic  mulDivOp;
    logic  mulDivPending;
    logic  mulDivStart;
    logic  accepted;
    word_t result;
    word_t seqPc;
    word_t dstValue;
    logic  branchTaken;
    word_t nextPc;

    operandBypass bypass0 (
        .clk        (clk),
        .reset      (reset),
        .writeEnable(accepted && regWriteEnable),
        .writeAddr  (dstRegAddr),
        .writeValue (dstValue),
        .readAddr1  (srcRegAddr1),
        .readAddr2  (srcRegAddr2),
        .regValue1  (srcRegValue1),
        .regValue2  (srcRegValue2),
        .value1     (srcValue1),
        .value2     (srcValue2)
    );

    always_comb begin
        case (aluSrc1Type)
            src1Pc:  aluSrc1 = pc;
            src1Reg: aluSrc1 = srcValue1;
            default: aluSrc1 = '0;
        endcase
        case (aluSrc2Type)
            src2Imm: aluSrc2 = imm;
            src2Reg: aluSrc2 = srcValue2;
            default: aluSrc2 = '0;
        endcase
    end

    intAlu alu0 (
        .command   (aluCommand),
        .src1      (aluSrc1),
        .src2      (aluSrc2),
        .branchType(branchType),
        .cmpSrc1   (srcValue1),
        .cmpSrc2   (srcValue2),
        .result    (aluResult),
        .condition (condition)
    );

    // start once per op; pending covers the cycles until done
    assign mulDivOp = valid && exUnitType == exUnitMulDiv;
    assign mulDivStart = mulDivOp && !mulDivPending;
    assign stall = mulDivOp && !mulDivDone;
    assign accepted = valid && !stall;

    always_ff @(posedge clk) begin
        if (reset || mulDivDone) begin
            mulDivPending <= 1'b0;
        end else if (mulDivStart) begin
            mulDivPending <= 1'b1;
        end
    end

    mulDivUnit mulDiv0 (
        .clk       (clk),
        .reset     (reset),
        .start     (mulDivStart),
        .mulDivType(mulDivType),
        .src1      (srcValue1),
        .src2      (srcValue2),
        .done      (mulDivDone),
        .result    (mulDivResult)
    );

    assign result = exUnitType == exUnitMulDiv ? mulDivResult : aluResult;
    assign seqPc = pc + INSN_SIZE;
    assign dstValue = dstSrcType == dstNextPc ? seqPc : result;
    assign branchTaken = isBranch && condition;
    assign nextPc = branchTaken ? aluResult : seqPc;

    // bubble into the output register while stalled
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            outValid <= 1'b0;
            outRegWrite <= 1'b0;
            outDstRegAddr <= '0;
            outDstValue <= '0;
            outBranchTaken <= 1'b0;
            outNextPc <= '0;
        end else begin
            outValid <= valid;
            outRegWrite <= valid && regWriteEnable;
            outDstRegAddr <= dstRegAddr;
            outDstValue <= dstValue;
            outBranchTaken <= valid && branchTaken;
            outNextPc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- hw/intAlu.sv
// ----------------------------------------
// integer ALU and branch comparator, purely combinational
// shifts use the low five bits of src2 only
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module intAlu import execTypes::*; (
    input  aluCommand_t command,
    input  word_t       src1,
    input  word_t       src2,
    input  branchType_t branchType,
    input  word_t       cmpSrc1,
    input  word_t       cmpSrc2,
    output word_t       result,
    output logic        condition
);

    logic [XLEN_LOG2-1:0] shamt;

    assign shamt = src2[XLEN_LOG2-1:0];

    always_comb begin
        case (command)
            aluAdd:    result = src1 + src2;
            aluSub:    result = src1 - src2;
            aluSll:    result = src1 << shamt;
            aluSlt:    result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            aluSltu:   result = {{(XLEN-1){1'b0}}, src1 < src2};
            aluXor:    result = src1 ^ src2;
            aluSrl:    result = src1 >> shamt;
            aluSra:    result = $signed(src1) >>> shamt;
            aluOr:     result = src1 | src2;
            aluAnd:    result = src1 & src2;
            aluClear1: result = src1 & ~src2;
            aluClear2: result = ~src1 & src2;
            default:   result = '0;
        endcase
    end

    // compares the register operands, not the ALU sources
    always_comb begin
        case (branchType)
            branchEqual:                condition = cmpSrc1 == cmpSrc2;
            branchNotEqual:             condition = cmpSrc1 != cmpSrc2;
            branchLessThan:             condition = $signed(cmpSrc1) < $signed(cmpSrc2);
            branchGreaterEqual:         condition = $signed(cmpSrc1) >= $signed(cmpSrc2);
            branchUnsignedLessThan:     condition = cmpSrc1 < cmpSrc2;
            branchUnsignedGreaterEqual: condition = cmpSrc1 >= cmpSrc2;
            branchAlways:               condition = 1'b1;
            default:                    condition = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mulDivUnit.sv
// ----------------------------------------
// multi-cycle multiply / divide, one op at a time
// start only while idle; operands are latched at start
// done pulses one cycle: 2 cycles for mul, 33 for div/rem
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit import execTypes::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  mulDivType_t mulDivType,
    input  word_t       src1,
    input  word_t       src2,
    output logic        done,
    output word_t       result
);

    typedef enum logic [1:0] {
        stIdle,
        stMul,
        stDiv,
        stDone
    } state_t;

    state_t                 state;
    logic [XLEN_LOG2-1:0]   count;
    mulDivType_t            cmd;
    logic                   srcSigned1;
    logic                   srcSigned2;
    logic [XLEN:0]          extSrc1;
    logic [XLEN:0]          extSrc2;
    logic [XLEN:0]          opA;
    logic [XLEN:0]          opB;
    logic signed [2*XLEN+1:0] productFull;
    logic [2*XLEN-1:0]      product;
    word_t                  quot;
    word_t                  rem;
    word_t                  divisor;
    logic                   negQuot;
    logic                   negRem;
    logic                   divByZero;
    logic [XLEN:0]          partial;
    logic [XLEN:0]          diff;
    word_t                  quotFixed;
    word_t                  remFixed;

    // sign extension to 33 bits per operand kind
    assign srcSigned1 = mulDivType inside {mdMulh, mdMulhsu, mdDiv, mdRem};
    assign srcSigned2 = mulDivType inside {mdMulh, mdDiv, mdRem};
    assign extSrc1 = {srcSigned1 & src1[XLEN-1], src1};
    assign extSrc2 = {srcSigned2 & src2[XLEN-1], src2};

    assign productFull = $signed(opA) * $signed(opB);

    // restoring step: shift in next dividend bit, try subtract
    assign partial = {rem, quot[XLEN-1]};
    assign diff = partial - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            count <= '0;
        end else begin
            case (state)
                stIdle: begin
                    count <= '0;
                    if (start) begin
                        state <= mulDivType[2] ? stDiv : stMul;
                    end
                end
                stMul: state <= stDone;
                stDiv: begin
                    count <= count + 1'b1;
                    if (count == XLEN_LOG2'(XLEN - 1)) begin
                        state <= stDone;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == stIdle) begin
            cmd <= mulDivType;
            opA <= extSrc1;
            opB <= extSrc2;
            // divider works on magnitudes
            quot <= extSrc1[XLEN] ? -src1 : src1;
            divisor <= extSrc2[XLEN] ? -src2 : src2;
            rem <= '0;
            negQuot <= extSrc1[XLEN] ^ extSrc2[XLEN];
            negRem <= extSrc1[XLEN];
            divByZero <= src2 == '0;
        end else if (state == stMul) begin
            product <= productFull[2*XLEN-1:0];
        end else if (state == stDiv) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quot <= {quot[XLEN-2:0], 1'b1};
            end else begin
                rem <= partial[XLEN-1:0];
                quot <= {quot[XLEN-2:0], 1'b0};
            end
        end
    end

    // x/0 gives all ones; remainder already equals the dividend
    assign quotFixed = divByZero ? '1 : (negQuot ? -quot : quot);
    assign remFixed = negRem ? -rem : rem;

    assign done = state == stDone;

    always_comb begin
        case (cmd)
            mdMul:          result = product[XLEN-1:0];
            mdDiv, mdDivu:  result = quotFixed;
            mdRem, mdRemu:  result = remFixed;
            default:        result = product[2*XLEN-1:XLEN];
        endcase
    end

endmodule

`default_nettype wire

//--- hw/operandBypass.sv
// ----------------------------------------
// single-entry forwarding from the last retired write
// x0 never hits; entry holds until the next write
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module operandBypass import execTypes::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  word_t    writeValue,
    input  regAddr_t readAddr1,
    input  regAddr_t readAddr2,
    input  word_t    regValue1,
    input  word_t    regValue2,
    output word_t    value1,
    output word_t    value2
);

    logic     entryValid;
    regAddr_t entryAddr;
    word_t    entryValue;
    logic     hit1;
    logic     hit2;

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= 1'b0;
        end else if (writeEnable) begin
            entryValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            entryAddr <= writeAddr;
            entryValue <= writeValue;
        end
    end

    assign hit1 = entryValid && entryAddr == readAddr1 && readAddr1 != '0;
    assign hit2 = entryValid && entryAddr == readAddr2 && readAddr2 != '0;

    assign value1 = hit1 ? entryValue : regValue1;
    assign value2 = hit2 ? entryValue : regValue2;

endmodule

`default_nettype wire

//--- rvExecute.f
hw/execTypes.sv
hw/intAlu.sv
hw/mulDivUnit.sv
hw/operandBypass.sv
hw/executeStage.sv
testbench/executeStageTb.sv

//--- testbench/executeStageTb.sv
// ----------------------------------------
// random and directed checks of the execute stage
// expected results come from a reference model and a
// forwarding model; register addresses stay in x0..x3
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module executeStageTb import execTypes::*; ();

    localparam int TIMEOUT_CYCLES = 300 * 40 + 2000;

    typedef struct packed {
        regAddr_t addr;
        logic     regWrite;
        word_t    value;
        logic     taken;
        word_t    nextPc;
    } expected_t;

    logic         clk;
    logic         reset;
    logic         valid;
    exUnitType_t  exUnitType;
    aluCommand_t  aluCommand;
    aluSrc1Type_t aluSrc1Type;
    aluSrc2Type_t aluSrc2Type;
    mulDivType_t  mulDivType;
    logic         isBranch;
    branchType_t  branchType;
    dstSrcType_t  dstSrcType;
    logic         regWriteEnable;
    regAddr_t     srcRegAddr1;
    regAddr_t     srcRegAddr2;
    regAddr_t     dstRegAddr;
    word_t        srcRegValue1;
    word_t        srcRegValue2;
    word_t        pc;
    word_t        imm;
    logic         stall;
    logic         outValid;
    logic         outRegWrite;
    regAddr_t     outDstRegAddr;
    word_t        outDstValue;
    logic         outBranchTaken;
    word_t        outNextPc;

    expected_t    expQueue[$];
    logic         fwdValid;
    regAddr_t     fwdAddr;
    word_t        fwdValue;
    int           cycleCount;

    executeStage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("TEST FAIL");
        $fatal(1, "run stopped on a failed check");
    endtask

    task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
        assert (actVal === expVal) else begin
            $display("ERROR time=%0t %s expected %h actual %h", $time, name, expVal, actVal);
            stopWithFailure();
        end
    endtask

    function automatic word_t aluRef(aluCommand_t cmd, word_t a, word_t b);
        case (cmd)
            aluAdd:    return a + b;
            aluSub:    return a - b;
            aluSll:    return a << b[4:0];
            aluSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu:   return (a < b) ? 32'd1 : 32'd0;
            aluXor:    return a ^ b;
            aluSrl:    return a >> b[4:0];
            aluSra:    return $signed(a) >>> b[4:0];
            aluOr:     return a | b;
            aluAnd:    return a & b;
            aluClear1: return a & ~b;
            aluClear2: return ~a & b;
            default:   return '0;
        endcase
    endfunction

    function automatic word_t mulDivRef(mulDivType_t md, word_t a, word_t b);
        logic [63:0]        sa;
        logic [63:0]        sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic               overflow;
        logic signed [31:0] quotient;
        logic signed [31:0] remainder;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        overflow = a == 32'h8000_0000 && b == 32'hffff_ffff;
        quotient = '0;
        remainder = '0;
        // signed quotient and remainder, truncating toward zero
        if (b != 0 && !overflow) begin
            quotient = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
        end
        case (md)
            mdMul:    return (ua * ub) >> 0;
            mdMulh:   return (sa * sb) >> 32;
            mdMulhsu: return (sa * ub) >> 32;
            mdMulhu:  return (ua * ub) >> 32;
            mdDiv:    return b == 0 ? '1 : (overflow ? a : quotient);
            mdDivu:   return b == 0 ? '1 : a / b;
            mdRem:    return b == 0 ? a : (overflow ? '0 : remainder);
            default:  return b == 0 ? a : a % b;
        endcase
    endfunction

    function automatic logic branchRef(branchType_t bt, word_t a, word_t b);
        case (bt)
            branchEqual:                return a == b;
            branchNotEqual:             return a != b;
            branchLessThan:             return $signed(a) < $signed(b);
            branchGreaterEqual:         return $signed(a) >= $signed(b);
            branchUnsignedLessThan:     return a < b;
            branchUnsignedGreaterEqual: return a >= b;
            branchAlways:               return 1'b1;
            default:                    return 1'b0;
        endcase
    endfunction

    // expected outputs from forwarded operands op1 and op2
    function automatic expected_t referenceResult(word_t op1, word_t op2);
        expected_t e;
        word_t     a;
        word_t     b;
        word_t     aluOut;
        word_t     seqPc;
        a = aluSrc1Type == src1Pc ? pc : (aluSrc1Type == src1Reg ? op1 : '0);
        b = aluSrc2Type == src2Imm ? imm : (aluSrc2Type == src2Reg ? op2 : '0);
        aluOut = aluRef(aluCommand, a, b);
        seqPc = pc + 32'd4;
        e.addr = dstRegAddr;
        e.regWrite = regWriteEnable;
        e.taken = isBranch && branchRef(branchType, op1, op2);
        e.nextPc = e.taken ? aluOut : seqPc;
        if (dstSrcType == dstNextPc) begin
            e.value = seqPc;
        end else if (exUnitType == exUnitMulDiv) begin
            e.value = mulDivRef(mulDivType, op1, op2);
        end else begin
            e.value = aluOut;
        end
        return e;
    endfunction

    function automatic word_t randomValue();
        case ($urandom_range(0, 7))
            0: return 32'h0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return 32'h7fff_ffff;
            4: return $urandom_range(0, 40);
            default: return $urandom;
        endcase
    endfunction

    // no timing here; call right after a rising edge
    task automatic randomFields();
        valid <= 1'b1;
        exUnitType <= exUnitAlu;
        aluCommand <= aluCommand_t'($urandom_range(0, 11));
        aluSrc1Type <= aluSrc1Type_t'($urandom_range(0, 2));
        aluSrc2Type <= aluSrc2Type_t'($urandom_range(0, 2));
        mulDivType <= mulDivType_t'($urandom_range(0, 7));
        isBranch <= 1'b0;
        branchType <= branchType_t'($urandom_range(0, 6));
        dstSrcType <= dstResult;
        regWriteEnable <= $urandom_range(0, 3) != 0;
        srcRegAddr1 <= regAddr_t'($urandom_range(0, 3));
        srcRegAddr2 <= regAddr_t'($urandom_range(0, 3));
        dstRegAddr <= regAddr_t'($urandom_range(0, 3));
        srcRegValue1 <= randomValue();
        srcRegValue2 <= randomValue();
        pc <= $urandom & 32'hffff_fffc;
        imm <= randomValue();
    endtask

    // waits out any stall, then queues the expected result
    task automatic finishOp();
        word_t     op1;
        word_t     op2;
        expected_t e;
        do @(negedge clk); while (stall);
        op1 = (fwdValid && fwdAddr == srcRegAddr1 && srcRegAddr1 != 0) ? fwdValue : srcRegValue1;
        op2 = (fwdValid && fwdAddr == srcRegAddr2 && srcRegAddr2 != 0) ? fwdValue : srcRegValue2;
        e = referenceResult(op1, op2);
        expQueue.push_back(e);
        if (regWriteEnable) begin
            fwdValid = 1'b1;
            fwdAddr = dstRegAddr;
            fwdValue = e.value;
        end
    endtask

    // bubble cycle with random fields behind a low valid
    task automatic idleCycle();
        @(posedge clk);
        randomFields();
        valid <= 1'b0;
        isBranch <= 1'b1;
    endtask

    task automatic mulDivOp(input mulDivType_t md, input word_t a, input word_t b);
        @(posedge clk);
        randomFields();
        exUnitType <= exUnitMulDiv;
        mulDivType <= md;
        srcRegAddr1 <= '0;
        srcRegAddr2 <= '0;
        srcRegValue1 <= a;
        srcRegValue2 <= b;
        @(negedge clk);
        checkWord("stall", 32'd1, word_t'(stall));
        finishOp();
    endtask

    // compare every retired result against the queue head
    always @(negedge clk) begin
        expected_t e;
        if (!reset && outValid) begin
            assert (expQueue.size() > 0) else begin
                $display("outValid was high with no operation outstanding at %0t", $time);
                stopWithFailure();
            end
            e = expQueue.pop_front();
            checkWord("outDstRegAddr", word_t'(e.addr), word_t'(outDstRegAddr));
            checkWord("outRegWrite", word_t'(e.regWrite), word_t'(outRegWrite));
            checkWord("outDstValue", e.value, outDstValue);
            checkWord("outBranchTaken", word_t'(e.taken), word_t'(outBranchTaken));
            checkWord("outNextPc", e.nextPc, outNextPc);
        end else if (!reset) begin
            checkWord("outRegWrite", '0, word_t'(outRegWrite));
            checkWord("outBranchTaken", '0, word_t'(outBranchTaken));
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stopWithFailure();
        end
    end

    initial begin
        regAddr_t lastDst;
        word_t    v;
        void'($urandom(32'h9a8));
        cycleCount = 0;
        fwdValid = 1'b0;
        fwdAddr = '0;
        fwdValue = '0;
        lastDst = '0;
        reset = 1'b1;
        valid = 1'b0;
        exUnitType = exUnitAlu;
        aluCommand = aluAdd;
        aluSrc1Type = src1Zero;
        aluSrc2Type = src2Zero;
        mulDivType = mdMul;
        isBranch = 1'b0;
        branchType = branchEqual;
        dstSrcType = dstResult;
        regWriteEnable = 1'b0;
        srcRegAddr1 = '0;
        srcRegAddr2 = '0;
        dstRegAddr = '0;
        srcRegValue1 = '0;
        srcRegValue2 = '0;
        pc = '0;
        imm = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // quiet outputs after reset
        repeat (3) begin
            @(negedge clk);
            checkWord("outValid", '0, word_t'(outValid));
            checkWord("outRegWrite", '0, word_t'(outRegWrite));
            checkWord("outBranchTaken", '0, word_t'(outBranchTaken));
            checkWord("stall", '0, word_t'(stall));
        end

        // random ALU ops with occasional gaps
        repeat (120) begin
            if ($urandom_range(0, 7) == 0) begin
                idleCycle();
            end
            @(posedge clk);
            randomFields();
            finishOp();
        end

        // dependent chain through the forwarding entry and x0
        repeat (40) begin
            @(posedge clk);
            randomFields();
            regWriteEnable <= 1'b1;
            aluSrc1Type <= src1Reg;
            aluSrc2Type <= src2Reg;
            srcRegAddr1 <= lastDst;
            srcRegAddr2 <= $urandom_range(0, 1) ? lastDst : regAddr_t'(0);
            finishOp();
            lastDst = dstRegAddr;
        end

        // branches of every type and link writes
        repeat (40) begin
            v = randomValue();
            @(posedge clk);
            randomFields();
            isBranch <= 1'b1;
            aluCommand <= aluAdd;
            aluSrc1Type <= src1Pc;
            aluSrc2Type <= src2Imm;
            dstSrcType <= dstSrcType_t'($urandom_range(0, 1));
            if ($urandom_range(0, 1)) begin
                srcRegAddr1 <= '0;
                srcRegAddr2 <= '0;
                srcRegValue1 <= v;
                srcRegValue2 <= v;
            end
            finishOp();
        end

        // multiply and divide with corner operands first
        for (int k = 0; k < 8; k++) begin
            mulDivOp(mulDivType_t'(k), $urandom, 32'h0);
            mulDivOp(mulDivType_t'(k), 32'h8000_0000, 32'hffff_ffff);
            mulDivOp(mulDivType_t'(k), randomValue(), randomValue());
        end

        // random mix in issue order
        repeat (80) begin
            @(posedge clk);
            randomFields();
            if ($urandom_range(0, 3) == 0) begin
                exUnitType <= exUnitMulDiv;
            end
            isBranch <= $urandom_range(0, 1);
            dstSrcType <= dstSrcType_t'($urandom_range(0, 3) == 0);
            finishOp();
        end

        idleCycle();
        repeat (4) @(negedge clk);
        if (expQueue.size() != 0) begin
            $display("%0d expected results never appeared on the outputs", expQueue.size());
            stopWithFailure();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
